/* verilog.f */
+incdir+hw
hw/mips_pkg.sv
hw/mem_if.sv
hw/regfile.sv
hw/alu.sv
hw/multiplier.sv
hw/controller.sv
hw/datapath.sv
hw/bus_bridge.sv
hw/mips_core.sv
verif/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mips_core_tb -f verilog.f -o mips_core_sim \
  && ./obj_dir/mips_core_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verif/mips_core_tb.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core_tb import mips_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int ROM_WORDS = 64;
  // a lw or sw takes up to 14 cycles when both ack delays are at their maximum
  localparam int MAX_CPI = 14;
  // dynamic instruction counts over all runs of all tests
  localparam int TOTAL_INSTR = 17 + 8 + 7 + 3 * 8 + 4 * 7;
  localparam int RUNS = 10;
  localparam int WATCHDOG_NS = (TOTAL_INSTR * MAX_CPI + RUNS * 16) * CLK_PERIOD * 2;

  logic  clk;
  logic  rst_n;
  word_t pc;
  word_t instr;
  logic  mem_req;
  logic  mem_we;
  word_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;
  logic  mem_ack;

  word_t rom [ROM_WORDS];
  word_t dmem [word_t];
  int    prog_len;
  word_t rng_state = 32'd85;

  word_t exp_addr_q[$];
  word_t exp_data_q[$];
  word_t st_addr_q[$];
  word_t st_data_q[$];
  word_t exp_trace_q[$];
  word_t trace_q[$];

  int    error_count = 0;
  int    check_count = 0;
  int    tests_run = 0;
  int    tests_failed = 0;

  word_t last_pc;
  logic  last_busy;
  logic  last_req;
  logic  last_ack;

  mips_core dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .instr     (instr),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_ack   (mem_ack)
  );

  // instruction fetch is combinational from pc
  assign instr = rom[pc[7:2]];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t xorshift32();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // contents of data memory that was never written
  function automatic word_t fill_word(input word_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic word_t sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t rtype_word(input logic [5:0] funct, input int rs, input int rt,
                                       input int rd);
    return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
  endfunction

  function automatic word_t itype_word(input logic [5:0] op, input int rs, input int rt,
                                       input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic word_t jtype_word(input logic [5:0] op, input word_t target);
    return {op, target[27:2]};
  endfunction

  // taken branch goes to pc+4 plus the word offset
  function automatic word_t branch_target(input word_t at, input logic [15:0] imm);
    return at + 32'd4 + (sext16(imm) << 2);
  endfunction

  // j and jal keep the top nibble of pc+4
  function automatic word_t jump_target(input word_t at, input word_t iw);
    word_t next;
    next = at + 32'd4;
    return {next[31:28], iw[25:0], 2'b00};
  endfunction

  function automatic word_t here();
    return word_t'(prog_len * 4);
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    check_count++;
    assert (actual == expected) else begin
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic put_instr(input word_t w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  // hold the core in reset and clear everything a run leaves behind
  task automatic begin_test();
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    prog_len = 0;
    exp_addr_q.delete();
    exp_data_q.delete();
    st_addr_q.delete();
    st_data_q.delete();
    exp_trace_q.delete();
    trace_q.delete();
    dmem.delete();
  endtask

  task automatic run_program(input word_t end_pc, input int n_instr);
    int cycles;
    int limit;
    cycles = 0;
    limit = n_instr * MAX_CPI + 8;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (pc != end_pc && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    assert (pc == end_pc) else begin
      $display("program never reached its final jump at %h, pc is %h after %0d cycles",
               end_pc, pc, cycles);
      error_count++;
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic check_stores();
    int n;
    check_word("store count", word_t'(exp_addr_q.size()), word_t'(st_addr_q.size()));
    n = (exp_addr_q.size() < st_addr_q.size()) ? exp_addr_q.size() : st_addr_q.size();
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("mem_addr[%0d]", i), exp_addr_q[i], st_addr_q[i]);
      check_word($sformatf("mem_wdata[%0d]", i), exp_data_q[i], st_data_q[i]);
    end
  endtask

  task automatic check_trace();
    int n;
    check_word("pc trace length", word_t'(exp_trace_q.size()), word_t'(trace_q.size()));
    n = (exp_trace_q.size() < trace_q.size()) ? exp_trace_q.size() : trace_q.size();
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("pc[%0d]", i), exp_trace_q[i], trace_q[i]);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic arithmetic_ops();
    int          errors_before;
    word_t       rnd;
    word_t       a;
    word_t       b;
    logic [15:0] ia;
    logic [15:0] ib;
    logic [15:0] ic;
    errors_before = error_count;
    begin_test();
    rnd = xorshift32();
    ia = rnd[15:0];
    ib = rnd[31:16];
    rnd = xorshift32();
    ic = rnd[15:0];
    a = sext16(ia);
    b = sext16(ib);
    put_instr(itype_word(`OP_ADDI, 0, 1, ia));
    put_instr(itype_word(`OP_ADDI, 0, 2, ib));
    put_instr(rtype_word(`FN_ADD, 1, 2, 3));
    put_instr(rtype_word(`FN_SUB, 1, 2, 4));
    put_instr(rtype_word(`FN_AND, 1, 2, 5));
    put_instr(rtype_word(`FN_OR, 1, 2, 6));
    put_instr(rtype_word(`FN_SLT, 1, 2, 7));
    put_instr(rtype_word(`FN_SLT, 2, 1, 8));
    put_instr(itype_word(`OP_ADDI, 1, 9, ic));
    for (int r = 3; r <= 9; r++) begin
      put_instr(itype_word(`OP_SW, 0, r, 16'(16'h0100 + (r - 3) * 4)));
    end
    put_instr(jtype_word(`OP_J, here()));
    expect_store(32'h100, a + b);
    expect_store(32'h104, a - b);
    expect_store(32'h108, a & b);
    expect_store(32'h10c, a | b);
    expect_store(32'h110, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    expect_store(32'h114, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    expect_store(32'h118, a + sext16(ic));
    run_program(here() - 32'd4, 17);
    check_stores();
    report_test("arithmetic", errors_before);
  endtask

  task automatic branch_and_jump();
    int errors_before;
    errors_before = error_count;
    begin_test();
    put_instr(itype_word(`OP_ADDI, 0, 1, 16'd5));
    put_instr(itype_word(`OP_ADDI, 0, 2, 16'd5));
    put_instr(itype_word(`OP_BEQ, 1, 2, 16'd2));
    put_instr(itype_word(`OP_ADDI, 0, 3, 16'd1));
    put_instr(itype_word(`OP_ADDI, 0, 3, 16'd2));
    put_instr(itype_word(`OP_ADDI, 0, 2, 16'd7));
    put_instr(itype_word(`OP_BEQ, 1, 2, 16'd3));
    put_instr(jtype_word(`OP_J, 32'h28));
    put_instr(itype_word(`OP_ADDI, 0, 3, 16'd3));
    put_instr(itype_word(`OP_ADDI, 0, 3, 16'd4));
    // r3 stays zero only if every skipped addi was skipped
    put_instr(itype_word(`OP_SW, 0, 3, 16'h0200));
    put_instr(jtype_word(`OP_J, here()));
    exp_trace_q = {32'h0, 32'h4, 32'h8};
    exp_trace_q.push_back(branch_target(32'h8, 16'd2));
    exp_trace_q.push_back(32'h18);
    exp_trace_q.push_back(32'h18 + 32'd4);
    exp_trace_q.push_back(jump_target(32'h1c, rom[7]));
    exp_trace_q.push_back(32'h2c);
    expect_store(32'h200, 32'h0);
    run_program(32'h2c, 8);
    check_trace();
    check_stores();
    report_test("branch and jump", errors_before);
  endtask

  task automatic link_and_return();
    int errors_before;
    errors_before = error_count;
    begin_test();
    put_instr(itype_word(`OP_ADDI, 0, 4, 16'd9));
    put_instr(jtype_word(`OP_JAL, 32'h14));
    put_instr(itype_word(`OP_SW, 0, 31, 16'h0300));
    put_instr(itype_word(`OP_SW, 0, 4, 16'h0304));
    put_instr(jtype_word(`OP_J, 32'h10));
    put_instr(itype_word(`OP_ADDI, 4, 4, 16'd1));
    put_instr(rtype_word(`FN_JR, 31, 0, 0));
    exp_trace_q = {32'h0, 32'h4};
    exp_trace_q.push_back(jump_target(32'h4, rom[1]));
    exp_trace_q.push_back(32'h18);
    // jr lands on the link value that jal wrote
    exp_trace_q.push_back(32'h4 + 32'd4);
    exp_trace_q.push_back(32'hc);
    exp_trace_q.push_back(32'h10);
    expect_store(32'h300, 32'h4 + 32'd4);
    expect_store(32'h304, 32'd10);
    run_program(32'h10, 7);
    check_trace();
    check_stores();
    report_test("link and return", errors_before);
  endtask

  task automatic multiply_hilo();
    int                 errors_before;
    word_t              op_a;
    word_t              op_b;
    logic signed [63:0] prod;
    errors_before = error_count;
    for (int k = 0; k < 3; k++) begin
      begin_test();
      op_a = xorshift32();
      op_b = xorshift32();
      // later passes force negative operands
      if (k > 0) begin
        op_a[31] = 1'b1;
      end
      if (k > 1) begin
        op_b[31] = 1'b1;
      end
      dmem[32'h400] = op_a;
      dmem[32'h404] = op_b;
      prod = 64'($signed(op_a)) * 64'($signed(op_b));
      put_instr(itype_word(`OP_LW, 0, 1, 16'h0400));
      put_instr(itype_word(`OP_LW, 0, 2, 16'h0404));
      put_instr(rtype_word(`FN_MULT, 1, 2, 0));
      put_instr(rtype_word(`FN_MFHI, 0, 0, 3));
      put_instr(rtype_word(`FN_MFLO, 0, 0, 4));
      put_instr(itype_word(`OP_SW, 0, 3, 16'h0408));
      put_instr(itype_word(`OP_SW, 0, 4, 16'h040c));
      put_instr(jtype_word(`OP_J, here()));
      expect_store(32'h408, prod[63:32]);
      expect_store(32'h40c, prod[31:0]);
      run_program(32'h1c, 8);
      check_stores();
    end
    report_test("multiply", errors_before);
  endtask

  task automatic load_store_stall();
    int    errors_before;
    word_t v;
    errors_before = error_count;
    for (int k = 0; k < 4; k++) begin
      begin_test();
      v = xorshift32();
      dmem[32'h500] = v;
      put_instr(itype_word(`OP_LW, 0, 1, 16'h0500));
      put_instr(itype_word(`OP_SW, 0, 1, 16'h0504));
      put_instr(itype_word(`OP_LW, 0, 2, 16'h0504));
      put_instr(itype_word(`OP_SW, 0, 2, 16'h0508));
      put_instr(itype_word(`OP_LW, 0, 3, 16'h050c));
      put_instr(itype_word(`OP_SW, 0, 3, 16'h0510));
      put_instr(jtype_word(`OP_J, here()));
      expect_store(32'h504, v);
      expect_store(32'h508, v);
      expect_store(32'h510, fill_word(32'h50c));
      run_program(32'h18, 7);
      check_stores();
    end
    report_test("load/store stall", errors_before);
  endtask

  // memory side of the four-phase bus
  // ack rises and falls after random delays
  initial begin : data_memory
    int delay;
    mem_ack = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge clk);
      if (mem_req && !mem_ack) begin
        delay = int'(xorshift32() % 32'd6);
        repeat (delay) @(negedge clk);
        if (mem_we) begin
          dmem[mem_addr] = mem_wdata;
          st_addr_q.push_back(mem_addr);
          st_data_q.push_back(mem_wdata);
        end else begin
          mem_rdata = dmem.exists(mem_addr) ? dmem[mem_addr] : fill_word(mem_addr);
        end
        mem_ack = 1'b1;
      end else if (!mem_req && mem_ack) begin
        delay = int'(xorshift32() % 32'd6);
        repeat (delay) @(negedge clk);
        mem_ack = 1'b0;
      end
    end
  end

  // sees the values that settled before this edge
  always @(posedge clk) begin : bus_monitor
    if (rst_n) begin
      if (last_busy) begin
        check_word("pc", last_pc, pc);
      end
      assert (!(mem_req && !last_req && last_ack)) else begin
        $display("mem_req rose at %0t ns while mem_ack was still high", $time);
        error_count++;
      end
      if (trace_q.size() == 0 || trace_q[$] != pc) begin
        trace_q.push_back(pc);
      end
      last_busy = mem_req || mem_ack;
      last_pc = pc;
      last_req = mem_req;
      last_ack = mem_ack;
    end else begin
      last_busy = 1'b0;
      last_req = 1'b0;
      last_ack = 1'b0;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    prog_len = 0;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    arithmetic_ops();
    branch_and_jump();
    link_and_return();
    multiply_hilo();
    load_store_stall();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output word_t pc,
  input  word_t instr,
  output logic  mem_req,
  output logic  mem_we,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  word_t mem_rdata,
  input  logic  mem_ack
);

  logic      memtoreg;
  logic      pcsrc;
  logic      alusrc;
  logic      regdst;
  logic      regwrite;
  logic      jump;
  logic      jumpreg;
  logic      link;
  logic      mult;
  logic      mfhi;
  logic      mflo;
  logic      zero;
  alu_ctrl_t alucontrol;

  mem_if mem_bus ();

  controller u_ctrl (
    .instr      (instr),
    .zero       (zero),
    .mem        (mem_bus),
    .memtoreg   (memtoreg),
    .pcsrc      (pcsrc),
    .alusrc     (alusrc),
    .regdst     (regdst),
    .regwrite   (regwrite),
    .jump       (jump),
    .jumpreg    (jumpreg),
    .link       (link),
    .mult       (mult),
    .mfhi       (mfhi),
    .mflo       (mflo),
    .alucontrol (alucontrol)
  );

  datapath u_dp (
    .clk        (clk),
    .rst_n      (rst_n),
    .memtoreg   (memtoreg),
    .pcsrc      (pcsrc),
    .alusrc     (alusrc),
    .regdst     (regdst),
    .regwrite   (regwrite),
    .jump       (jump),
    .jumpreg    (jumpreg),
    .link       (link),
    .mult       (mult),
    .mfhi       (mfhi),
    .mflo       (mflo),
    .alucontrol (alucontrol),
    .zero       (zero),
    .pc         (pc),
    .instr      (instr),
    .mem        (mem_bus)
  );

  // external four-phase data bus
  bus_bridge u_bridge (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (mem_bus),
    .req   (mem_req),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata),
    .ack   (mem_ack)
  );

endmodule

/* hw/bus_bridge.sv */
`timescale 1ns/1ps

module bus_bridge import mips_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  mem_if.bridge mem,
  output logic  req,
  output logic  we,
  output word_t addr,
  output word_t wdata,
  input  word_t rdata,
  input  logic  ack
);

  bridge_state_e state;
  word_t         rdata_q;

  // four-phase handshake, a new req only starts after ack has fallen
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= bs_idle;
      req   <= 1'b0;
      we    <= 1'b0;
    end else begin
      case (state)
        bs_idle: begin
          if (mem.valid) begin
            state <= bs_req_high;
            req   <= 1'b1;
            we    <= mem.we;
          end
        end
        bs_req_high: begin
          if (ack) begin
            state <= bs_req_low;
            req   <= 1'b0;
          end
        end
        bs_req_low: begin
          if (!ack) begin
            state <= bs_done;
          end
        end
        default: state <= bs_idle;
      endcase
    end
  end

  // address and store data stay stable for the whole bus cycle
  always_ff @(posedge clk) begin
    if (state == bs_idle && mem.valid) begin
      addr  <= mem.addr;
      wdata <= mem.wdata;
    end
    // read data is only valid while ack is high
    if (state == bs_req_high && ack) begin
      rdata_q <= rdata;
    end
  end

  assign mem.rdata = rdata_q;
  // stall from decode until done, the load retires in done
  assign mem.stall = (state == bs_idle && mem.valid) ||
                     (state == bs_req_high) ||
                     (state == bs_req_low);

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module datapath import mips_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      memtoreg,
  input  logic      pcsrc,
  input  logic      alusrc,
  input  logic      regdst,
  input  logic      regwrite,
  input  logic      jump,
  input  logic      jumpreg,
  input  logic      link,
  input  logic      mult,
  input  logic      mfhi,
  input  logic      mflo,
  input  alu_ctrl_t alucontrol,
  output logic      zero,
  output word_t     pc,
  input  word_t     instr,
  mem_if.core       mem
);

  word_t     pcnext;
  word_t     pcplus4;
  word_t     pcbranch;
  word_t     pcjump;
  word_t     signimm;
  word_t     srca;
  word_t     srcb;
  word_t     rd2;
  word_t     aluout;
  word_t     hi;
  word_t     lo;
  word_t     alumult_out;
  word_t     result;
  word_t     rf_wd;
  reg_addr_t writereg;
  reg_addr_t rf_wa;
  logic      rf_we;
  logic      hilo_we;

  // pc holds while the bridge is busy with a load or store
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!mem.stall) begin
      pc <= pcnext;
    end
  end

  assign pcplus4  = pc + word_t'(4);
  assign signimm  = {{(`DWIDTH-16){instr[15]}}, instr[15:0]};
  assign pcbranch = pcplus4 + {signimm[`DWIDTH-3:0], 2'b00};
  assign pcjump   = {pcplus4[`DWIDTH-1:28], instr[25:0], 2'b00};

  // jr wins over a taken branch, which wins over j/jal
  always_comb begin
    if (jumpreg) begin
      pcnext = srca;
    end else if (pcsrc) begin
      pcnext = pcbranch;
    end else if (jump) begin
      pcnext = pcjump;
    end else begin
      pcnext = pcplus4;
    end
  end

  // no architectural update while stalled
  assign rf_we   = regwrite & ~mem.stall;
  assign hilo_we = mult & ~mem.stall;

  // write-back address and data, link forces r31 and pc+4
  assign writereg = regdst ? instr[15:11] : instr[20:16];
  assign rf_wa    = link ? reg_addr_t'(`NREGS-1) : writereg;
  assign result   = memtoreg ? mem.rdata : alumult_out;
  assign rf_wd    = link ? pcplus4 : result;

  regfile rf (
    .clk   (clk),
    .rst_n (rst_n),
    .we3   (rf_we),
    .ra1   (instr[25:21]),
    .ra2   (instr[20:16]),
    .wa3   (rf_wa),
    .wd3   (rf_wd),
    .rd1   (srca),
    .rd2   (rd2)
  );

  assign srcb = alusrc ? signimm : rd2;

  alu u_alu (
    .in_a     (srca),
    .in_b     (srcb),
    .alu_op   (alucontrol),
    .alu_out  (aluout),
    .alu_zero (zero)
  );

  multiplier mult_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_a     (srca),
    .in_b     (rd2),
    .write_en (hilo_we),
    .out_hi   (hi),
    .out_lo   (lo)
  );

  // mfhi/mflo replace the alu result
  always_comb begin
    if (mfhi) begin
      alumult_out = hi;
    end else if (mflo) begin
      alumult_out = lo;
    end else begin
      alumult_out = aluout;
    end
  end

  // effective address and store data go to the bridge
  assign mem.addr  = aluout;
  assign mem.wdata = rd2;

endmodule

/* hw/controller.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module controller import mips_pkg::*; (
  input  word_t     instr,
  input  logic      zero,
  mem_if.core       mem,
  output logic      memtoreg,
  output logic      pcsrc,
  output logic      alusrc,
  output logic      regdst,
  output logic      regwrite,
  output logic      jump,
  output logic      jumpreg,
  output logic      link,
  output logic      mult,
  output logic      mfhi,
  output logic      mflo,
  output alu_ctrl_t alucontrol
);

  logic [5:0] op;
  logic [5:0] funct;
  logic [1:0] aluop;
  logic       branch;
  logic       mem_valid;
  logic       mem_we;

  assign op    = instr[31:26];
  assign funct = instr[5:0];

  // main decoder
  // aluop 00 add, 01 sub, 10 follow funct
  always_comb begin
    memtoreg  = 1'b0;
    alusrc    = 1'b0;
    regdst    = 1'b0;
    regwrite  = 1'b0;
    jump      = 1'b0;
    jumpreg   = 1'b0;
    link      = 1'b0;
    mult      = 1'b0;
    mfhi      = 1'b0;
    mflo      = 1'b0;
    branch    = 1'b0;
    mem_valid = 1'b0;
    mem_we    = 1'b0;
    aluop     = 2'b00;
    case (op)
      `OP_RTYPE: begin
        regdst = 1'b1;
        aluop  = 2'b10;
        case (funct)
          `FN_JR:   jumpreg = 1'b1;
          `FN_MULT: mult = 1'b1;
          `FN_MFHI: begin
            mfhi     = 1'b1;
            regwrite = 1'b1;
          end
          `FN_MFLO: begin
            mflo     = 1'b1;
            regwrite = 1'b1;
          end
          default:  regwrite = 1'b1;
        endcase
      end
      `OP_LW: begin
        regwrite  = 1'b1;
        alusrc    = 1'b1;
        memtoreg  = 1'b1;
        mem_valid = 1'b1;
      end
      `OP_SW: begin
        alusrc    = 1'b1;
        mem_valid = 1'b1;
        mem_we    = 1'b1;
      end
      `OP_BEQ: begin
        branch = 1'b1;
        aluop  = 2'b01;
      end
      `OP_ADDI: begin
        regwrite = 1'b1;
        alusrc   = 1'b1;
      end
      `OP_J:   jump = 1'b1;
      `OP_JAL: begin
        jump     = 1'b1;
        link     = 1'b1;
        regwrite = 1'b1;
      end
      default: ;
    endcase
  end

  // alu decoder, unknown functs fall back to add
  always_comb begin
    case (aluop)
      2'b00:   alucontrol = alu_add;
      2'b01:   alucontrol = alu_sub;
      default: begin
        case (funct)
          `FN_SUB: alucontrol = alu_sub;
          `FN_AND: alucontrol = alu_and;
          `FN_OR:  alucontrol = alu_or;
          `FN_SLT: alucontrol = alu_slt;
          default: alucontrol = alu_add;
        endcase
      end
    endcase
  end

  assign pcsrc     = branch & zero;
  assign mem.valid = mem_valid;
  assign mem.we    = mem_we;

endmodule

/* hw/multiplier.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module multiplier import mips_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  word_t in_a,
  input  word_t in_b,
  input  logic  write_en,
  output word_t out_hi,
  output word_t out_lo
);

  logic signed [2*`DWIDTH-1:0] product;

  // full signed product, split into hi and lo halves
  assign product = $signed(in_a) * $signed(in_b);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_hi <= '0;
      out_lo <= '0;
    end else if (write_en) begin
      out_hi <= product[2*`DWIDTH-1:`DWIDTH];
      out_lo <= product[`DWIDTH-1:0];
    end
  end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  word_t     in_a,
  input  word_t     in_b,
  input  alu_ctrl_t alu_op,
  output word_t     alu_out,
  output logic      alu_zero
);

  word_t sum;
  word_t b_mux;
  logic  less;

  // sub and slt share the adder with b inverted and a carry in
  assign b_mux = alu_op[2] ? ~in_b : in_b;
  assign sum   = in_a + b_mux + word_t'(alu_op[2]);

  // signed compare
  assign less = $signed(in_a) < $signed(in_b);

  always_comb begin
    case (alu_op)
      alu_and: alu_out = in_a & in_b;
      alu_or:  alu_out = in_a | in_b;
      alu_add: alu_out = sum;
      alu_sub: alu_out = sum;
      alu_slt: alu_out = word_t'(less);
      default: alu_out = '0;
    endcase
  end

  // used by beq
  assign alu_zero = (alu_out == '0);

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module regfile import mips_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      we3,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa3,
  input  word_t     wd3,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [`NREGS];

  // r0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we3 && wa3 != '0) begin
      regs[wa3] <= wd3;
    end
  end

  // asynchronous read ports
  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

endmodule

/* hw/mem_if.sv */
`timescale 1ns/1ps

// data-memory request between the core and the bus bridge
interface mem_if import mips_pkg::*; ();
  logic  valid;
  logic  we;
  word_t addr;
  word_t wdata;
  word_t rdata;
  logic  stall;

  // controller and datapath side
  modport core (output valid, output we, output addr, output wdata,
                input rdata, input stall);

  // bus bridge side
  modport bridge (input valid, input we, input addr, input wdata,
                  output rdata, output stall);

endinterface

/* hw/mips_pkg.sv */
`include "mips_defs.svh"

package mips_pkg;

  // one machine word, used for data and addresses alike
  typedef logic [`DWIDTH-1:0] word_t;

  // register file index
  typedef logic [$clog2(`NREGS)-1:0] reg_addr_t;

  // alu operation select
  typedef logic [2:0] alu_ctrl_t;

  // alu operation codes
  // bit 2 selects the inverted b operand for sub and slt
  localparam alu_ctrl_t alu_and = 3'b000;
  localparam alu_ctrl_t alu_or  = 3'b001;
  localparam alu_ctrl_t alu_add = 3'b010;
  localparam alu_ctrl_t alu_sub = 3'b110;
  localparam alu_ctrl_t alu_slt = 3'b111;

  // four-phase bus bridge states
  //   bs_idle      no transfer, waiting for a load or store
  //   bs_req_high  req asserted, waiting for ack
  //   bs_req_low   req dropped, waiting for ack to fall
  //   bs_done      transfer finished, instruction retires here
  typedef enum logic [1:0] {
    bs_idle,
    bs_req_high,
    bs_req_low,
    bs_done
  } bridge_state_e;

endpackage

/* hw/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data path and address width
`define DWIDTH 32
`define NREGS 32

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_ADDI 6'h08
`define OP_LW 6'h23
`define OP_SW 6'h2b

// r-type function codes, instr[5:0]
`define FN_JR 6'h08
`define FN_MFHI 6'h10
`define FN_MFLO 6'h12
`define FN_MULT 6'h18
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_SLT 6'h2a

`endif
